/* design/x25519_consts.svh */
`ifndef X25519_CONSTS_SVH
`define X25519_CONSTS_SVH

// Width of a field element, sum or result.
// Matches the 264-bit datapath of the adder.
`define X25519_FELEM_W 264

// First bit of a sum that is folded back into the low part.
`define X25519_FOLD_BIT 255

// 2^255 is congruent to 19 mod p, so folded bits are scaled by this.
`define X25519_FOLD_MUL 19

// The prime p = 2^255 - 19.
`define X25519_P \
	264'h00_7fff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffed

// 4p = 2^257 - 76.
// Added in place of a subtraction so a difference never goes negative.
`define X25519_FOUR_P \
	264'h01_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff_ffb4

`endif

/* design/x25519_field_pkg.sv */
`include "x25519_consts.svh"

// Types for values that live in the field datapath.
package x25519_field_pkg;

	// Field element, also used for raw sums and reduced results.
	// Legal operands stay below 2^256.
	// The extra top bits absorb carries and the 4p offset.
	typedef logic [`X25519_FELEM_W-1:0] felem_t;

	// Bits 263 down to 255 of a sum.
	// These get multiplied by 19 and added back into the low part.
	typedef logic [`X25519_FELEM_W-`X25519_FOLD_BIT-1:0] fold_hi_t;

endpackage

/* design/x25519_op_pkg.sv */
`include "x25519_consts.svh"

// Operation codes accepted by the field unit.
package x25519_op_pkg;

	// One bit is enough for add or subtract.
	typedef logic [0:0] field_op_t;

	// Sum a + b.
	localparam field_op_t OP_ADD = 1'b0;

	// Difference a - b.
	localparam field_op_t OP_SUB = 1'b1;

endpackage

/* design/x25519_operand_stage.sv */
`timescale 1ns/1ps
`include "x25519_consts.svh"

// Input stage of the field unit.
// Captures the operands and turns a subtraction into an addition.
module x25519_operand_stage
	import x25519_field_pkg::*;
	import x25519_op_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      en,
	input  field_op_t op,
	input  felem_t    a,
	input  felem_t    b,
	output logic      opnd_valid,
	output felem_t    opnd_a,
	output felem_t    opnd_b
);

	// Second operand as the adder will see it.
	felem_t b_sel;

	// For a difference use 4p - b instead of -b.
	// Since b < 2^256 < 4p the result stays positive.
	// Adding it to a gives a value congruent to a - b mod p.
	always_comb begin
		if (op == OP_SUB) begin
			b_sel = `X25519_FOUR_P - b;
		end else begin
			b_sel = b;
		end
	end

	// Valid flag follows en by one cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			opnd_valid <= 1'b0;
		end else begin
			opnd_valid <= en;
		end
	end

	// Operand registers load only on a new operation.
	// They hold their value otherwise.
	always_ff @(posedge clk) begin
		if (en) begin
			opnd_a <= a;
			opnd_b <= b_sel;
		end
	end

endmodule

/* design/x25519_add.sv */
`timescale 1ns/1ps

// Two-cycle pipelined 264-bit adder.
// The carry chain is cut at bit 128 to keep each half short.
module x25519_add
	import x25519_field_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   en,
	input  felem_t a,
	input  felem_t b,
	output logic   out_valid,
	output felem_t out
);

	// Low half width and the remaining high half.
	localparam int LO_W = 128;
	localparam int HI_W = $bits(felem_t) - LO_W;

	// Low partial sum keeps its carry-out in the top bit.
	logic [LO_W:0]   sum_low;
	logic [HI_W-1:0] sum_high;

	// Marks that the partial sums hold a live item.
	logic en_ff;

	// Enable pipeline, cleared by reset.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_ff     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			en_ff     <= en;
			out_valid <= en_ff;
		end
	end

	// First cycle adds the halves independently.
	// Second cycle ripples the low carry into the high half.
	always_ff @(posedge clk) begin
		if (en) begin
			sum_low  <= a[LO_W-1:0] + b[LO_W-1:0];
			sum_high <= a[$bits(felem_t)-1:LO_W] + b[$bits(felem_t)-1:LO_W];
		end
		if (en_ff) begin
			out <= {sum_high + HI_W'(sum_low[LO_W]), sum_low[LO_W-1:0]};
		end
	end

endmodule

/* design/x25519_fold.sv */
`timescale 1ns/1ps
`include "x25519_consts.svh"

// Partial reduction.
// Bits 255 and up are worth 19 each, so they are folded into the low part.
module x25519_fold
	import x25519_field_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   sum_valid,
	input  felem_t sum,
	output logic   fold_valid,
	output felem_t fold
);

	// Width of the fold constant, 19 needs five bits.
	localparam int             MUL_W = 5;
	localparam logic [MUL_W-1:0] MUL = MUL_W'(`X25519_FOLD_MUL);

	logic [`X25519_FOLD_BIT-1:0] sum_lo;
	fold_hi_t                    sum_hi;
	felem_t                      hi_mul;

	// Split the sum at the fold position.
	assign sum_lo = sum[`X25519_FOLD_BIT-1:0];
	assign sum_hi = sum[`X25519_FELEM_W-1:`X25519_FOLD_BIT];

	// Constant multiply as shift and add, one term per set bit.
	// 19 = 16 + 2 + 1, so three terms; at most 19 * 511 = 9709.
	always_comb begin
		hi_mul = '0;
		for (int i = 0; i < MUL_W; i++) begin
			if (MUL[i]) begin
				hi_mul = hi_mul + (felem_t'(sum_hi) << i);
			end
		end
	end

	// Result is below 2^255 + 9709, so under 2p.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fold_valid <= 1'b0;
		end else begin
			fold_valid <= sum_valid;
		end
		if (sum_valid) begin
			fold <= felem_t'(sum_lo) + hi_mul;
		end
	end

endmodule

/* design/x25519_freeze.sv */
`timescale 1ns/1ps
`include "x25519_consts.svh"

// Final reduction to the canonical range 0 to p - 1.
// The input is already below 2p, so one conditional subtract is enough.
module x25519_freeze
	import x25519_field_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   fold_valid,
	input  felem_t fold,
	output logic   out_valid,
	output felem_t out
);

	// One extra bit catches the borrow of fold - p.
	logic [`X25519_FELEM_W:0] diff_ext;

	// High when fold is at least p.
	logic ge_p;

	// A clear borrow means fold >= p.
	assign diff_ext = {1'b0, fold} - {1'b0, `X25519_P};
	assign ge_p     = !diff_ext[`X25519_FELEM_W];

	// Result pulse to the top level.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= fold_valid;
		end
	end

	// Output holds its last value between pulses.
	always_ff @(posedge clk) begin
		if (fold_valid) begin
			if (ge_p) begin
				out <= diff_ext[`X25519_FELEM_W-1:0];
			end else begin
				out <= fold;
			end
		end
	end

endmodule

/* design/x25519_field_alu.sv */
`timescale 1ns/1ps

// Pipelined add and subtract unit for GF(2^255 - 19).
// Four cycles from en to out_valid, one new operation per cycle.
module x25519_field_alu
	import x25519_field_pkg::*;
	import x25519_op_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      en,
	input  field_op_t op,
	input  felem_t    a,
	input  felem_t    b,
	output logic      out_valid,
	output felem_t    out
);

	// Operand stage to adder.
	logic   opnd_valid;
	felem_t opnd_a;
	felem_t opnd_b;

	// Adder to fold stage.
	logic   sum_valid;
	felem_t sum;

	// Fold stage to freeze stage.
	logic   fold_valid;
	felem_t fold;

	// Edge N, capture operands and apply the 4p offset.
	x25519_operand_stage i_operand (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.op         (op),
		.a          (a),
		.b          (b),
		.opnd_valid (opnd_valid),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b)
	);

	// Edges N+1 and N+2, split 264-bit addition.
	x25519_add i_add (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (opnd_valid),
		.a         (opnd_a),
		.b         (opnd_b),
		.out_valid (sum_valid),
		.out       (sum)
	);

	// Edge N+3, fold the top bits back in.
	x25519_fold i_fold (
		.clk        (clk),
		.rst_n      (rst_n),
		.sum_valid  (sum_valid),
		.sum        (sum),
		.fold_valid (fold_valid),
		.fold       (fold)
	);

	// Edge N+4, canonical result.
	x25519_freeze i_freeze (
		.clk        (clk),
		.rst_n      (rst_n),
		.fold_valid (fold_valid),
		.fold       (fold),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule

/* testbench/x25519_field_alu_asserts.sv */
`timescale 1ns/1ps
`include "x25519_consts.svh"

// Timing and range checks on the field unit, bound into its top level.
module x25519_field_alu_asserts
	import x25519_field_pkg::*;
(
	input logic   clk,
	input logic   rst_n,
	input logic   en,
	input logic   out_valid,
	input felem_t out
);

	// Number of failed assertions, watched by the testbench.
	int unsigned fail_count = 0;

	// Reset clears every valid flag.
	// The edge of reset and the one after it show no result.
	a_quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !out_valid ##1 !out_valid)
	else begin
		fail_count++;
		$error("out_valid high during or right after reset");
	end

	// Five flops from en to out_valid.
	// out_valid is registered at edge N+4 and sampled here at N+5.
	a_en_gives_result: assert property (@(posedge clk) disable iff (!rst_n)
		en |-> ##5 out_valid)
	else begin
		fail_count++;
		$error("accepted operation gave no result after four cycles");
	end

	// Every pulse traces back to exactly one accepted operation.
	a_result_has_en: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(en, 5))
	else begin
		fail_count++;
		$error("result pulse without a matching accepted operation");
	end

	// Canonical range 0 to p - 1.
	a_result_below_p: assert property (@(posedge clk)
		out_valid |-> (out < `X25519_P))
	else begin
		fail_count++;
		$error("result not below p");
	end

endmodule

bind x25519_field_alu x25519_field_alu_asserts i_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.en        (en),
	.out_valid (out_valid),
	.out       (out)
);

/* testbench/x25519_field_alu_tb.sv */
`timescale 1ns/1ps
`include "x25519_consts.svh"

// Testbench for the pipelined GF(2^255 - 19) add and subtract unit.
module x25519_field_alu_tb
	import x25519_field_pkg::*;
	import x25519_op_pkg::*;
();

	// Test lengths.
	localparam int N_DIRECTED      = 7;
	localparam int N_RANDOM        = 300;
	localparam int N_GAPPED        = 100;
	localparam int MAX_GAP         = 3;
	localparam int N_BURST_PRE     = 12;
	localparam int N_BURST_POST    = 24;
	localparam int INIT_RST_CYCLES = 5;
	// Long enough that every in-flight check lands inside reset.
	localparam int MID_RST_CYCLES  = 6;
	localparam int DRAIN_CYCLES    = 3;
	localparam int LATENCY         = 4;
	localparam int MARGIN          = 20;

	// Cycle budget for the whole run.
	localparam int N_OPS = N_DIRECTED + N_RANDOM + N_GAPPED + N_BURST_PRE + N_BURST_POST;
	localparam int GAP_CYCLES = INIT_RST_CYCLES + N_GAPPED * MAX_GAP
		+ (MID_RST_CYCLES + 1) + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = N_OPS + GAP_CYCLES + LATENCY + MARGIN;

	localparam logic [31:0] SEED = 32'h9eb7_8070;

	// Clock, reset and DUT ports.
	logic      clk = 1'b0;
	logic      rst_n;
	logic      en;
	field_op_t op;
	felem_t    a;
	felem_t    b;
	logic      out_valid;
	felem_t    out;

	// Expected results and their test names, oldest first.
	felem_t exp_q[$];
	string  name_q[$];

	// Rising edges since time zero.
	int unsigned cycle_cnt = 0;

	x25519_field_alu i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.out       (out)
	);

	// 40 ns period.
	always #20 clk = ~clk;

	// Expected (a + b) mod p or (a - b) mod p.
	// Reduces each operand first, then one correction step.
	function automatic felem_t field_ref(field_op_t op_v, felem_t x, felem_t y);
		felem_t p_val;
		felem_t xr;
		felem_t yr;
		felem_t r;
		p_val = `X25519_P;
		xr = x % p_val;
		yr = y % p_val;
		if (op_v == OP_SUB) begin
			if (xr >= yr) begin
				r = xr - yr;
			end else begin
				r = xr + (p_val - yr);
			end
		end else begin
			r = xr + yr;
			if (r >= p_val) begin
				r = r - p_val;
			end
		end
		return r;
	endfunction

	// Random legal operand below 2^256.
	function automatic felem_t random_elem();
		felem_t v;
		v = '0;
		for (int w = 0; w < 8; w++) begin
			v[32*w +: 32] = $urandom();
		end
		return v;
	endfunction

	function automatic field_op_t random_op();
		return field_op_t'($urandom() & 32'h1);
	endfunction

	// Prints the fail line and stops.
	task automatic abort_run(input string why);
		$display("Some tests failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_felem(input string name, input felem_t expected, input felem_t actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			abort_run("Result value mismatch.");
		end
	endtask

	// No pulse may appear while nothing is outstanding.
	task automatic check_idle(input logic valid);
		if (valid !== 1'b0) begin
			abort_run("Unexpected result, out_valid pulsed with no operation outstanding.");
		end
	endtask

	// One operation, sampled at the next rising edge.
	task automatic issue_op(input string name, input field_op_t op_v,
		input felem_t a_v, input felem_t b_v);
		@(posedge clk);
		#2;
		en = 1'b1;
		op = op_v;
		a  = a_v;
		b  = b_v;
		exp_q.push_back(field_ref(op_v, a_v, b_v));
		name_q.push_back(name);
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
			en = 1'b0;
		end
	endtask

	// Reset in the middle of traffic.
	// Results already out before the first reset edge still get checked.
	task automatic apply_reset(input int cycles);
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		en    = 1'b0;
		repeat (cycles) @(posedge clk);
		#2;
		// Anything still queued was flushed by reset.
		exp_q.delete();
		name_q.delete();
		rst_n = 1'b1;
	endtask

	// Compare at the falling edge, where outputs are stable.
	always @(negedge clk) begin
		felem_t expected;
		string  name;
		if (exp_q.size() == 0) begin
			check_idle(out_valid);
		end else if (out_valid === 1'b1) begin
			expected = exp_q.pop_front();
			name     = name_q.pop_front();
			check_felem(name, expected, out);
		end
	end

	// Concurrent assertions count their failures in the bound module.
	always @(negedge clk) begin
		if (i_dut.i_asserts.fail_count != 0) begin
			abort_run("A concurrent assertion on the DUT failed.");
		end
	end

	// Run length limit.
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout after %0d cycles with %0d results outstanding.",
				cycle_cnt, exp_q.size()));
		end
	end

	initial begin
		felem_t p_val;
		felem_t ones;
		felem_t x;
		int     gap;
		void'($urandom(SEED));
		p_val = `X25519_P;
		ones  = felem_t'({256{1'b1}});
		rst_n = 1'b0;
		en    = 1'b0;
		op    = OP_ADD;
		a     = '0;
		b     = '0;
		repeat (INIT_RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Directed sums.
		issue_op("add_zero", OP_ADD, '0, '0);
		issue_op("add_p_minus_1_plus_1", OP_ADD, p_val - 1, felem_t'(1));
		issue_op("add_p_plus_p", OP_ADD, p_val, p_val);
		issue_op("add_max_plus_max", OP_ADD, ones, ones);

		// Directed differences, the last one needs the whole 4p offset.
		x = random_elem();
		issue_op("sub_x_minus_x", OP_SUB, x, x);
		issue_op("sub_zero_minus_1", OP_SUB, '0, felem_t'(1));
		issue_op("sub_zero_minus_max", OP_SUB, '0, ones);

		// Full throughput.
		for (int i = 0; i < N_RANDOM; i++) begin
			issue_op($sformatf("random_%0d", i), random_op(), random_elem(), random_elem());
		end

		// Idle gaps between operations.
		for (int i = 0; i < N_GAPPED; i++) begin
			issue_op($sformatf("gapped_%0d", i), random_op(), random_elem(), random_elem());
			gap = $urandom_range(MAX_GAP, 0);
			drive_idle(gap);
		end

		// Burst, reset with items in flight, then a new burst.
		for (int i = 0; i < N_BURST_PRE; i++) begin
			issue_op($sformatf("pre_reset_%0d", i), random_op(), random_elem(), random_elem());
		end
		apply_reset(MID_RST_CYCLES);
		for (int i = 0; i < N_BURST_POST; i++) begin
			issue_op($sformatf("post_reset_%0d", i), random_op(), random_elem(), random_elem());
		end

		// Drain and watch for stray pulses.
		drive_idle(1);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);

		if (i_dut.i_asserts.fail_count != 0) begin
			abort_run("A concurrent assertion on the DUT failed.");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

/* x25519_field_alu.f */
+incdir+design
design/x25519_field_pkg.sv
design/x25519_op_pkg.sv
design/x25519_operand_stage.sv
design/x25519_add.sv
design/x25519_fold.sv
design/x25519_freeze.sv
design/x25519_field_alu.sv
testbench/x25519_field_alu_asserts.sv
testbench/x25519_field_alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the field unit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

TOP=x25519_field_alu_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" --Mdir "$BUILD_DIR" \
	-f x25519_field_alu.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

# A raised error limit lets the testbench see assertion failures itself.
"./$BUILD_DIR/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
